//--- common/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

	typedef logic [15:0] instr_t;		// one instruction word
	typedef logic [3:0] reg_idx_t;		// register file index
	typedef logic [15:0] reg_mask_t;	// one active low strobe per register
	typedef logic [4:0] alu_op_t;		// bit 4 set for single register ops
	typedef logic [11:0] imm_t;		// pending prefix bits
	typedef logic [15:0] word_t;		// data / pout value
	typedef logic [2:0] cond_t;		// branch condition code

	typedef struct packed {
		logic c;	// carry
		logic z;	// zero
		logic s;	// sign
	} flags_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic [3:0] pout_lo;		// low nibble of pout
		reg_mask_t ld_alu_b;		// load from alu result
		reg_mask_t ld_mem_b;		// load from memory bus
		reg_mask_t ld_pout_b;		// load from pout
		reg_idx_t alu_a_sel;
		reg_idx_t alu_b_sel;
		logic alu_b_from_pout_b;	// 0 = alu b bus from pout
		logic m_en_b;			// register drives memory data bus
		reg_idx_t m_sel;
		reg_idx_t maddr_sel;		// register driving the address bus
		reg_mask_t inc_b;
		reg_mask_t dec_b;
		logic mem_oe_b;
		logic mem_wr_b;
	} ctrl_t;

	typedef enum logic [1:0] {
		FETCH_RUN = 2'd0,	// normal fetch
		FETCH_STALL = 2'd1,	// load data cycle, no fetch
		FETCH_DELAY = 2'd2	// branch delay slot, fetch but discard
	} fetch_mode_e;

	localparam reg_idx_t PC_REG = 4'd15;
	localparam instr_t NOP_INSTR = 16'h0000;

	// instruction classes, top nibble
	localparam logic [3:0] OP_INCDEC = 4'h0;
	localparam logic [3:0] OP_IMM = 4'h1;
	localparam logic [3:0] OP_ALU_RR = 4'h2;
	localparam logic [3:0] OP_ALU_RI = 4'h3;
	localparam logic [3:0] OP_BRANCH = 4'h4;
	localparam logic [3:0] OP_MEM = 4'h5;
	localparam logic [3:0] SUB_INC = 4'h2;		// sub-codes under class 0
	localparam logic [3:0] SUB_DEC = 4'h3;
	localparam logic [3:0] SUB_ALU1 = 4'h4;

	localparam int CLASS_MSB = 15;
	localparam int CLASS_LSB = 12;
	localparam int OP_MSB = 11;
	localparam int OP_LSB = 8;
	localparam int DST_MSB = 7;		// dest / data register
	localparam int DST_LSB = 4;
	localparam int SRC_MSB = 3;		// source, index or imm nibble
	localparam int SRC_LSB = 0;
	localparam int COND_MSB = 10;
	localparam int COND_LSB = 8;
	localparam int IMM_MSB = 11;		// prefix payload
	localparam int INDIRECT_BIT = 11;
	localparam int STORE_BIT = 8;
	localparam int NO_INC_BIT = 9;		// 0 = post-increment index
	localparam int NO_DEC_BIT = 10;		// 0 = post-decrement index

	localparam cond_t COND_Z = 3'd0;
	localparam cond_t COND_NZ = 3'd1;
	localparam cond_t COND_S = 3'd2;
	localparam cond_t COND_NS = 3'd3;
	localparam cond_t COND_C = 3'd4;
	localparam cond_t COND_NC = 3'd5;
	localparam cond_t COND_ALWAYS = 3'd6;
	localparam cond_t COND_RSVD = 3'd7;	// was branch-link, never taken

	localparam ctrl_t CTRL_IDLE = '{
		alu_op: '0, pout_lo: '0,
		ld_alu_b: '1, ld_mem_b: '1, ld_pout_b: '1,
		alu_a_sel: '0, alu_b_sel: '0, alu_b_from_pout_b: 1'b1,
		m_en_b: 1'b1, m_sel: '0, maddr_sel: '0,
		inc_b: '1, dec_b: '1, mem_oe_b: 1'b1, mem_wr_b: 1'b1
	};

endpackage

`default_nettype wire

//--- pipeline/fetch_stage.sv
`default_nettype none

module fetch_stage (
	input wire logic CLK,
	input wire logic RSTb,
	input wire cpu_ctrl_pkg::instr_t mem_in,	// word on the memory bus
	input wire logic kill_fetch,			// from stage 0 decode
	input wire logic flush_req,			// store in stage 1
	input wire logic stall_req,			// load wants a data cycle
	input wire logic delay_req,			// taken branch
	input wire logic imm_load,			// prefix in stage 0
	output cpu_ctrl_pkg::instr_t p0_instr,
	output cpu_ctrl_pkg::instr_t p1_instr,
	output cpu_ctrl_pkg::imm_t imm,
	output cpu_ctrl_pkg::ctrl_t fetch_ctrl
);

	cpu_ctrl_pkg::fetch_mode_e mode;		// current fetch mode
	cpu_ctrl_pkg::fetch_mode_e mode_next;
	cpu_ctrl_pkg::instr_t p0_next;
	cpu_ctrl_pkg::imm_t imm_next;
	logic fetching;					// pc drives the address bus

	assign fetching = (mode == cpu_ctrl_pkg::FETCH_RUN) ||
		(mode == cpu_ctrl_pkg::FETCH_DELAY);

	// a fetched word only enters in run mode and when nobody drops it
	always_comb begin
		if ((mode != cpu_ctrl_pkg::FETCH_RUN) || kill_fetch || flush_req) begin
			p0_next = cpu_ctrl_pkg::NOP_INSTR;	// inject nop
		end else begin
			p0_next = mem_in;
		end
	end

	always_comb begin
		if (stall_req) begin
			mode_next = cpu_ctrl_pkg::FETCH_STALL;
		end else if (delay_req) begin
			mode_next = cpu_ctrl_pkg::FETCH_DELAY;
		end else begin
			mode_next = cpu_ctrl_pkg::FETCH_RUN;
		end
	end

	// prefix lives for exactly one instruction
	always_comb begin
		if (imm_load) begin
			imm_next = p0_instr[cpu_ctrl_pkg::IMM_MSB:0];
		end else begin
			imm_next = '0;
		end
	end

	// default controls, pc fetch with post-increment
	always_comb begin
		fetch_ctrl = cpu_ctrl_pkg::CTRL_IDLE;
		if (fetching) begin
			fetch_ctrl.maddr_sel = cpu_ctrl_pkg::PC_REG;
			fetch_ctrl.inc_b[cpu_ctrl_pkg::PC_REG] = 1'b0;	// pc++
			fetch_ctrl.mem_oe_b = 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			p0_instr <= cpu_ctrl_pkg::NOP_INSTR;
			p1_instr <= cpu_ctrl_pkg::NOP_INSTR;
			mode <= cpu_ctrl_pkg::FETCH_RUN;
			imm <= '0;
		end else begin
			p0_instr <= p0_next;
			p1_instr <= p0_instr;			// stage 1 always follows
			mode <= mode_next;
			imm <= imm_next;
		end
	end

endmodule

`default_nettype wire

//--- pipeline/decode_p0.sv
`default_nettype none

module decode_p0 (
	input wire cpu_ctrl_pkg::ctrl_t fetch_ctrl,	// default pc fetch controls
	input wire cpu_ctrl_pkg::instr_t p0_instr,
	input wire cpu_ctrl_pkg::imm_t imm,		// pending prefix
	input wire cpu_ctrl_pkg::flags_t flags,		// from alu
	output cpu_ctrl_pkg::ctrl_t p0_ctrl,
	output logic kill_fetch,
	output logic stall_req,
	output logic delay_req,
	output logic imm_load
);

	logic [3:0] op_class;
	logic [3:0] op;
	cpu_ctrl_pkg::reg_idx_t dst;
	cpu_ctrl_pkg::reg_idx_t src;			// also index and imm nibble
	cpu_ctrl_pkg::cond_t cond;
	logic taken;					// branch condition holds

	function automatic logic cond_holds(
		input cpu_ctrl_pkg::cond_t c,
		input cpu_ctrl_pkg::flags_t f
	);
		case (c)
			cpu_ctrl_pkg::COND_Z: cond_holds = f.z;
			cpu_ctrl_pkg::COND_NZ: cond_holds = !f.z;
			cpu_ctrl_pkg::COND_S: cond_holds = f.s;
			cpu_ctrl_pkg::COND_NS: cond_holds = !f.s;
			cpu_ctrl_pkg::COND_C: cond_holds = f.c;
			cpu_ctrl_pkg::COND_NC: cond_holds = !f.c;
			cpu_ctrl_pkg::COND_ALWAYS: cond_holds = 1'b1;
			cpu_ctrl_pkg::COND_RSVD: cond_holds = 1'b0;	// reserved code never branches
		endcase
	endfunction

	assign op_class = p0_instr[cpu_ctrl_pkg::CLASS_MSB:cpu_ctrl_pkg::CLASS_LSB];
	assign op = p0_instr[cpu_ctrl_pkg::OP_MSB:cpu_ctrl_pkg::OP_LSB];
	assign dst = p0_instr[cpu_ctrl_pkg::DST_MSB:cpu_ctrl_pkg::DST_LSB];
	assign src = p0_instr[cpu_ctrl_pkg::SRC_MSB:cpu_ctrl_pkg::SRC_LSB];
	assign cond = p0_instr[cpu_ctrl_pkg::COND_MSB:cpu_ctrl_pkg::COND_LSB];
	assign taken = !p0_instr[cpu_ctrl_pkg::INDIRECT_BIT] && cond_holds(cond, flags);

	always_comb begin
		p0_ctrl = fetch_ctrl;		// start from the fetch defaults
		kill_fetch = 1'b0;
		stall_req = 1'b0;
		delay_req = 1'b0;
		imm_load = 1'b0;
		case (op_class)
			cpu_ctrl_pkg::OP_IMM: begin
				imm_load = 1'b1;	// extends the next constant
			end
			cpu_ctrl_pkg::OP_INCDEC: begin
				case (op)
					cpu_ctrl_pkg::SUB_INC: p0_ctrl.inc_b[src] = 1'b0;
					cpu_ctrl_pkg::SUB_DEC: p0_ctrl.dec_b[src] = 1'b0;
					cpu_ctrl_pkg::SUB_ALU1: begin
						p0_ctrl.alu_op = {1'b1, dst};	// op sits in dest field
						p0_ctrl.alu_a_sel = src;
						p0_ctrl.alu_b_sel = src;
						p0_ctrl.ld_alu_b[src] = 1'b0;	// result back to src
					end
					default: ;			// nop and unused sub-codes
				endcase
			end
			cpu_ctrl_pkg::OP_ALU_RR: begin
				p0_ctrl.alu_op = {1'b0, op};
				p0_ctrl.alu_a_sel = dst;
				p0_ctrl.alu_b_sel = src;
				p0_ctrl.ld_alu_b[dst] = 1'b0;
			end
			cpu_ctrl_pkg::OP_ALU_RI: begin
				p0_ctrl.alu_op = {1'b0, op};
				p0_ctrl.alu_a_sel = dst;
				p0_ctrl.pout_lo = src;			// imm nibble onto pout
				p0_ctrl.alu_b_from_pout_b = 1'b0;	// b bus from pout
				p0_ctrl.ld_alu_b[dst] = 1'b0;
			end
			cpu_ctrl_pkg::OP_BRANCH: begin
				if (taken) begin
					p0_ctrl.pout_lo = src;		// target low nibble
					p0_ctrl.ld_pout_b[cpu_ctrl_pkg::PC_REG] = 1'b0;	// pc <= pout
					p0_ctrl.inc_b[cpu_ctrl_pkg::PC_REG] = 1'b1;
					kill_fetch = 1'b1;
					delay_req = 1'b1;		// one delay slot follows
				end
			end
			cpu_ctrl_pkg::OP_MEM: begin
				p0_ctrl.maddr_sel = src;		// index register
				if (p0_instr[cpu_ctrl_pkg::STORE_BIT]) begin
					p0_ctrl.m_en_b = 1'b0;
					p0_ctrl.m_sel = dst;		// data register
					p0_ctrl.mem_wr_b = 1'b0;
					p0_ctrl.mem_oe_b = 1'b1;	// bus belongs to the register
					p0_ctrl.inc_b[src] = p0_instr[cpu_ctrl_pkg::NO_INC_BIT];
					p0_ctrl.dec_b[src] = p0_instr[cpu_ctrl_pkg::NO_DEC_BIT];
				end else begin
					stall_req = 1'b1;		// data arrives next cycle
				end
				// hold pc and undo the increment of the last fetch
				p0_ctrl.inc_b[cpu_ctrl_pkg::PC_REG] = 1'b1;
				p0_ctrl.dec_b[cpu_ctrl_pkg::PC_REG] = 1'b0;
				kill_fetch = 1'b1;			// word on the bus is not code
			end
			default: ;	// classes 6 and up are nops
		endcase
	end

endmodule

`default_nettype wire

//--- pipeline/decode_p1.sv
`default_nettype none

module decode_p1 (
	input wire cpu_ctrl_pkg::ctrl_t p0_ctrl,	// stage 0 result
	input wire cpu_ctrl_pkg::instr_t p1_instr,
	output cpu_ctrl_pkg::ctrl_t ctrl,		// final controls
	output logic flush_req
);

	logic [3:0] p1_class;
	logic is_mem;					// memory class in stage 1
	logic is_store;
	cpu_ctrl_pkg::reg_idx_t dst;			// load destination
	cpu_ctrl_pkg::reg_idx_t idx;			// index register

	assign p1_class = p1_instr[cpu_ctrl_pkg::CLASS_MSB:cpu_ctrl_pkg::CLASS_LSB];
	assign is_mem = (p1_class == cpu_ctrl_pkg::OP_MEM);
	assign is_store = p1_instr[cpu_ctrl_pkg::STORE_BIT];
	assign dst = p1_instr[cpu_ctrl_pkg::DST_MSB:cpu_ctrl_pkg::DST_LSB];
	assign idx = p1_instr[cpu_ctrl_pkg::SRC_MSB:cpu_ctrl_pkg::SRC_LSB];

	// store drops the word fetched behind it
	assign flush_req = is_mem && is_store;

	// load data cycle, stage 0 holds a nop and fetch is off
	always_comb begin
		ctrl = p0_ctrl;
		if (is_mem && !is_store) begin
			ctrl.maddr_sel = idx;
			ctrl.mem_oe_b = 1'b0;		// memory drives the bus
			ctrl.mem_wr_b = 1'b1;
			ctrl.ld_mem_b[dst] = 1'b0;	// capture into destination
			ctrl.inc_b[idx] = p1_instr[cpu_ctrl_pkg::NO_INC_BIT];	// post inc
			ctrl.dec_b[idx] = p1_instr[cpu_ctrl_pkg::NO_DEC_BIT];	// post dec
		end
	end

endmodule

`default_nettype wire

//--- source/cpu_ctrl.sv
`default_nettype none

module cpu_ctrl (
	input wire logic CLK,
	input wire logic RSTb,
	input wire cpu_ctrl_pkg::instr_t mem_in,	// memory read data
	input wire cpu_ctrl_pkg::flags_t flags,		// alu flags
	output cpu_ctrl_pkg::alu_op_t alu_op,
	output cpu_ctrl_pkg::word_t pout,		// pipeline constant
	output cpu_ctrl_pkg::reg_mask_t ld_alu_b,
	output cpu_ctrl_pkg::reg_mask_t ld_mem_b,
	output cpu_ctrl_pkg::reg_mask_t ld_pout_b,
	output cpu_ctrl_pkg::reg_idx_t alu_a_sel,
	output cpu_ctrl_pkg::reg_idx_t alu_b_sel,
	output logic alu_b_from_pout_b,
	output logic m_en_b,
	output cpu_ctrl_pkg::reg_idx_t m_sel,
	output cpu_ctrl_pkg::reg_idx_t maddr_sel,
	output cpu_ctrl_pkg::reg_mask_t inc_b,
	output cpu_ctrl_pkg::reg_mask_t dec_b,
	output logic mem_oe_b,
	output logic mem_wr_b
);

	cpu_ctrl_pkg::instr_t p0_instr;
	cpu_ctrl_pkg::instr_t p1_instr;
	cpu_ctrl_pkg::imm_t imm;
	cpu_ctrl_pkg::ctrl_t fetch_ctrl;		// pc fetch defaults
	cpu_ctrl_pkg::ctrl_t p0_ctrl;
	cpu_ctrl_pkg::ctrl_t ctrl;			// after stage 1 overrides
	logic kill_fetch;
	logic flush_req;
	logic stall_req;
	logic delay_req;
	logic imm_load;

	fetch_stage i_fetch (.CLK, .RSTb, .mem_in, .kill_fetch, .flush_req, .stall_req,
		.delay_req, .imm_load, .p0_instr, .p1_instr, .imm, .fetch_ctrl);

	decode_p0 i_decode_p0 (.fetch_ctrl, .p0_instr, .imm, .flags, .p0_ctrl,
		.kill_fetch, .stall_req, .delay_req, .imm_load);

	decode_p1 i_decode_p1 (.p0_ctrl, .p1_instr, .ctrl, .flush_req);

	assign alu_op = ctrl.alu_op;
	assign pout = {imm, ctrl.pout_lo};		// prefix on top of the nibble
	assign ld_alu_b = ctrl.ld_alu_b;
	assign ld_mem_b = ctrl.ld_mem_b;
	assign ld_pout_b = ctrl.ld_pout_b;
	assign alu_a_sel = ctrl.alu_a_sel;
	assign alu_b_sel = ctrl.alu_b_sel;
	assign alu_b_from_pout_b = ctrl.alu_b_from_pout_b;
	assign m_en_b = ctrl.m_en_b;
	assign m_sel = ctrl.m_sel;
	assign maddr_sel = ctrl.maddr_sel;
	assign inc_b = ctrl.inc_b;
	assign dec_b = ctrl.dec_b;
	assign mem_oe_b = ctrl.mem_oe_b;
	assign mem_wr_b = ctrl.mem_wr_b;

endmodule

`default_nettype wire

//--- tb/cpu_ctrl_assertions.sv
`default_nettype none

module cpu_ctrl_assertions (
	input wire logic CLK,
	input wire logic RSTb,
	input wire logic mem_oe_b,
	input wire logic mem_wr_b,
	input wire logic m_en_b,
	input wire cpu_ctrl_pkg::reg_mask_t ld_alu_b,
	input wire cpu_ctrl_pkg::reg_mask_t ld_mem_b,
	input wire cpu_ctrl_pkg::reg_mask_t ld_pout_b
);

	// one driver on the memory bus at a time
	a_no_read_write: assert property (@(posedge CLK) disable iff (!RSTb)
		!(!mem_oe_b && !mem_wr_b))
		else $error("mem_oe_b and mem_wr_b low together");

	a_enable_with_write: assert property (@(posedge CLK) disable iff (!RSTb)
		!m_en_b |-> !mem_wr_b)
		else $error("m_en_b low outside a write");

	// at most one destination per load source
	a_one_alu_load: assert property (@(posedge CLK) disable iff (!RSTb)
		$countones(~ld_alu_b) <= 1)
		else $error("ld_alu_b has more than one low bit");

	a_one_mem_load: assert property (@(posedge CLK) disable iff (!RSTb)
		$countones(~ld_mem_b) <= 1)
		else $error("ld_mem_b has more than one low bit");

	a_one_pout_load: assert property (@(posedge CLK) disable iff (!RSTb)
		$countones(~ld_pout_b) <= 1)
		else $error("ld_pout_b has more than one low bit");

endmodule

bind cpu_ctrl cpu_ctrl_assertions i_assertions (.CLK, .RSTb, .mem_oe_b, .mem_wr_b, .m_en_b,
	.ld_alu_b, .ld_mem_b, .ld_pout_b);

`default_nettype wire

//--- tb/tb_cpu_ctrl.sv
`default_nettype none

module tb_cpu_ctrl;

	localparam int WORDS_PER_TEST = 200;
	localparam int NUM_WORDS = 6 * WORDS_PER_TEST;		// six focused tests
	localparam int CYCLE_LIMIT = NUM_WORDS * 3 + 50;
	localparam logic [31:0] SEED = 32'h498142e7;

	logic CLK;
	logic RSTb;
	cpu_ctrl_pkg::instr_t mem_in;
	cpu_ctrl_pkg::flags_t flags;
	cpu_ctrl_pkg::alu_op_t alu_op;
	cpu_ctrl_pkg::word_t pout;
	cpu_ctrl_pkg::reg_mask_t ld_alu_b;
	cpu_ctrl_pkg::reg_mask_t ld_mem_b;
	cpu_ctrl_pkg::reg_mask_t ld_pout_b;
	cpu_ctrl_pkg::reg_idx_t alu_a_sel;
	cpu_ctrl_pkg::reg_idx_t alu_b_sel;
	logic alu_b_from_pout_b;
	logic m_en_b;
	cpu_ctrl_pkg::reg_idx_t m_sel;
	cpu_ctrl_pkg::reg_idx_t maddr_sel;
	cpu_ctrl_pkg::reg_mask_t inc_b;
	cpu_ctrl_pkg::reg_mask_t dec_b;
	logic mem_oe_b;
	logic mem_wr_b;

	logic [31:0] lfsr_state;
	int cycle_count;
	int error_count;
	int check_count;
	cpu_ctrl_pkg::instr_t m_p0;			// model stage 0
	cpu_ctrl_pkg::instr_t m_p1;			// model stage 1
	cpu_ctrl_pkg::fetch_mode_e m_mode;
	cpu_ctrl_pkg::imm_t m_imm;			// model prefix register

	cpu_ctrl i_dut (.CLK, .RSTb, .mem_in, .flags, .alu_op, .pout, .ld_alu_b, .ld_mem_b,
		.ld_pout_b, .alu_a_sel, .alu_b_sel, .alu_b_from_pout_b, .m_en_b, .m_sel,
		.maddr_sel, .inc_b, .dec_b, .mem_oe_b, .mem_wr_b);

	always #50 CLK = ~CLK;

	always @(posedge CLK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the stimulus never finished", cycle_count);
			$display("TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// taps 32 22 2 1
	endfunction

	// one lfsr step per bit
	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = next_lfsr(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// half the words come from the focus class, the rest from any class
	function automatic cpu_ctrl_pkg::instr_t gen_word(input logic [2:0] focus);
		logic [15:0] r;
		logic [2:0] kind;
		r = take_bits(4);
		kind = r[3] ? focus : r[2:0];
		r = take_bits(12);
		case (kind)
			3'd0: return {4'h0, 4'h2 + {2'b00, r[11:10]}, r[7:0]};	// inc dec alu1 and unused 5
			3'd1: return {4'h1, r[11:0]};
			3'd2: return {4'h2, r[11:0]};
			3'd3: return {4'h3, r[11:0]};
			3'd4: return {4'h4, r[11] & r[3], r[10:0]};	// indirect one in four
			3'd5: return {4'h5, r[11:0]};
			3'd6: return {4'h6 + {1'b0, r[11:9]}, r[11:0]};	// dead classes 6 to 13
			default: return cpu_ctrl_pkg::NOP_INSTR;
		endcase
	endfunction

	function automatic logic branch_taken(input cpu_ctrl_pkg::instr_t w,
		input cpu_ctrl_pkg::flags_t f);
		logic hit;
		case (w[10:8])
			3'd0: hit = f.z;
			3'd1: hit = ~f.z;
			3'd2: hit = f.s;
			3'd3: hit = ~f.s;
			3'd4: hit = f.c;
			3'd5: hit = ~f.c;
			3'd6: hit = 1'b1;
			default: hit = 1'b0;		// reserved code
		endcase
		return hit && !w[11];			// indirect form decodes as nop
	endfunction

	// expected controls for the current model state
	function automatic cpu_ctrl_pkg::ctrl_t predict(input cpu_ctrl_pkg::flags_t f);
		cpu_ctrl_pkg::ctrl_t e;
		logic [3:0] a;
		logic [3:0] b;
		a = m_p0[7:4];
		b = m_p0[3:0];
		e = '0;
		e.ld_alu_b = '1;
		e.ld_mem_b = '1;
		e.ld_pout_b = '1;
		e.alu_b_from_pout_b = 1'b1;
		e.m_en_b = 1'b1;
		e.inc_b = '1;
		e.dec_b = '1;
		e.mem_oe_b = 1'b1;
		e.mem_wr_b = 1'b1;
		if ((m_mode == cpu_ctrl_pkg::FETCH_RUN) || (m_mode == cpu_ctrl_pkg::FETCH_DELAY)) begin
			e.maddr_sel = 4'd15;		// pc fetch
			e.inc_b[15] = 1'b0;
			e.mem_oe_b = 1'b0;
		end
		case (m_p0[15:12])
			4'h0: begin
				if (m_p0[11:8] == 4'h2) e.inc_b[b] = 1'b0;
				if (m_p0[11:8] == 4'h3) e.dec_b[b] = 1'b0;
				if (m_p0[11:8] == 4'h4) begin
					e.alu_op = {1'b1, a};	// single reg op sits in dest field
					e.alu_a_sel = b;
					e.alu_b_sel = b;
					e.ld_alu_b[b] = 1'b0;
				end
			end
			4'h2, 4'h3: begin
				e.alu_op = {1'b0, m_p0[11:8]};
				e.alu_a_sel = a;
				e.ld_alu_b[a] = 1'b0;
				if (m_p0[12]) begin
					e.pout_lo = b;		// immediate form
					e.alu_b_from_pout_b = 1'b0;
				end else begin
					e.alu_b_sel = b;
				end
			end
			4'h4: begin
				if (branch_taken(m_p0, f)) begin
					e.pout_lo = b;
					e.ld_pout_b[15] = 1'b0;
					e.inc_b[15] = 1'b1;
				end
			end
			4'h5: begin
				e.maddr_sel = b;
				if (m_p0[8]) begin
					e.m_en_b = 1'b0;
					e.m_sel = a;
					e.mem_wr_b = 1'b0;
					e.mem_oe_b = 1'b1;
					if (!m_p0[9]) e.inc_b[b] = 1'b0;
					if (!m_p0[10]) e.dec_b[b] = 1'b0;
				end
				e.inc_b[15] = 1'b1;		// pc held
				e.dec_b[15] = 1'b0;
			end
			default: ;
		endcase
		if ((m_p1[15:12] == 4'h5) && !m_p1[8]) begin
			e.maddr_sel = m_p1[3:0];		// load data cycle
			e.mem_oe_b = 1'b0;
			e.mem_wr_b = 1'b1;
			e.ld_mem_b[m_p1[7:4]] = 1'b0;
			e.inc_b[m_p1[3:0]] = m_p1[9];
			e.dec_b[m_p1[3:0]] = m_p1[10];
		end
		return e;
	endfunction

	task automatic step_model(input cpu_ctrl_pkg::instr_t w, input cpu_ctrl_pkg::flags_t f);
		logic is_br;
		logic stall;
		logic flush;
		is_br = (m_p0[15:12] == 4'h4) && branch_taken(m_p0, f);
		stall = (m_p0[15:12] == 4'h5) && !m_p0[8];
		flush = (m_p1[15:12] == 4'h5) && m_p1[8];
		m_imm = (m_p0[15:12] == 4'h1) ? m_p0[11:0] : 12'h000;
		m_p1 = m_p0;
		if ((m_mode != cpu_ctrl_pkg::FETCH_RUN) || is_br || (m_p0[15:12] == 4'h5) || flush)
			m_p0 = cpu_ctrl_pkg::NOP_INSTR;
		else
			m_p0 = w;
		if (stall) m_mode = cpu_ctrl_pkg::FETCH_STALL;
		else if (is_br) m_mode = cpu_ctrl_pkg::FETCH_DELAY;
		else m_mode = cpu_ctrl_pkg::FETCH_RUN;
	endtask

	task automatic check_mask(input string name, input cpu_ctrl_pkg::reg_mask_t got,
		input cpu_ctrl_pkg::reg_mask_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %s got %h expected %h cycle %0d", name, got, exp, cycle_count);
		end
	endtask

	task automatic check_idx(input string name, input cpu_ctrl_pkg::reg_idx_t got,
		input cpu_ctrl_pkg::reg_idx_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %s got %h expected %h cycle %0d", name, got, exp, cycle_count);
		end
	endtask

	task automatic check_op(input string name, input cpu_ctrl_pkg::alu_op_t got,
		input cpu_ctrl_pkg::alu_op_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %s got %h expected %h cycle %0d", name, got, exp, cycle_count);
		end
	endtask

	task automatic check_word(input string name, input cpu_ctrl_pkg::word_t got,
		input cpu_ctrl_pkg::word_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %s got %h expected %h cycle %0d", name, got, exp, cycle_count);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %s got %h expected %h cycle %0d", name, got, exp, cycle_count);
		end
	endtask

	task automatic check_outputs(input cpu_ctrl_pkg::ctrl_t e);
		check_op("alu_op", alu_op, e.alu_op);
		check_word("pout", pout, {m_imm, e.pout_lo});	// prefix over the nibble
		check_mask("ld_alu_b", ld_alu_b, e.ld_alu_b);
		check_mask("ld_mem_b", ld_mem_b, e.ld_mem_b);
		check_mask("ld_pout_b", ld_pout_b, e.ld_pout_b);
		check_idx("alu_a_sel", alu_a_sel, e.alu_a_sel);
		check_idx("alu_b_sel", alu_b_sel, e.alu_b_sel);
		check_bit("alu_b_from_pout_b", alu_b_from_pout_b, e.alu_b_from_pout_b);
		check_bit("m_en_b", m_en_b, e.m_en_b);
		check_idx("m_sel", m_sel, e.m_sel);
		check_idx("maddr_sel", maddr_sel, e.maddr_sel);
		check_mask("inc_b", inc_b, e.inc_b);
		check_mask("dec_b", dec_b, e.dec_b);
		check_bit("mem_oe_b", mem_oe_b, e.mem_oe_b);
		check_bit("mem_wr_b", mem_wr_b, e.mem_wr_b);
	endtask

	// bus rules that hold whatever the instruction mix
	task automatic check_rules();
		check_count++;
		if ((!mem_oe_b && !mem_wr_b) || (!m_en_b && mem_wr_b) || ($countones(~ld_alu_b) > 1) ||
			($countones(~ld_mem_b) > 1) || ($countones(~ld_pout_b) > 1)) begin
			error_count++;
			$display("memory strobes clash or a load mask has two low bits, cycle %0d",
				cycle_count);
		end
	endtask

	task automatic run_cycle(input cpu_ctrl_pkg::instr_t w);
		logic [15:0] r;
		cpu_ctrl_pkg::flags_t f;
		r = take_bits(3);
		f = cpu_ctrl_pkg::flags_t'(r[2:0]);
		mem_in = w;				// driven on the falling edge
		flags = f;
		#10;
		check_outputs(predict(f));
		check_rules();
		step_model(w, f);
		@(negedge CLK);
	endtask

	task automatic run_test(input string name, input logic [2:0] focus);
		int errors_before;
		int checks_before;
		errors_before = error_count;
		checks_before = check_count;
		for (int i = 0; i < WORDS_PER_TEST; i++) begin
			run_cycle(gen_word(focus));
		end
		$display("test %s: %0d checks, %0d errors", name, check_count - checks_before,
			error_count - errors_before);
	endtask

	initial begin
		CLK = 1'b0;
		RSTb = 1'b0;
		mem_in = cpu_ctrl_pkg::NOP_INSTR;
		flags = '0;
		lfsr_state = SEED;
		cycle_count = 0;
		error_count = 0;
		check_count = 0;
		m_p0 = cpu_ctrl_pkg::NOP_INSTR;
		m_p1 = cpu_ctrl_pkg::NOP_INSTR;
		m_mode = cpu_ctrl_pkg::FETCH_RUN;
		m_imm = '0;
		repeat (9) @(negedge CLK);
		#10;
		check_mask("inc_b", inc_b, 16'h7fff);	// only pc++ active
		check_idx("maddr_sel", maddr_sel, 4'hf);
		check_bit("mem_oe_b", mem_oe_b, 1'b0);
		check_outputs(predict(flags));
		check_rules();
		$display("test reset: %0d errors", error_count);
		@(negedge CLK);
		RSTb = 1'b1;
		run_test("incdec_alu1", 3'd0);
		run_test("prefix", 3'd1);
		run_test("alu_rr", 3'd2);
		run_test("alu_ri", 3'd3);
		run_test("branch", 3'd4);
		run_test("load_store", 3'd5);
		$display("total: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
common/cpu_ctrl_pkg.sv
pipeline/fetch_stage.sv
pipeline/decode_p0.sv
pipeline/decode_p1.sv
source/cpu_ctrl.sv
tb/cpu_ctrl_assertions.sv
tb/tb_cpu_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_cpu_ctrl
RTL_TOP ?= cpu_ctrl
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= TESTS FAILED
LINT_FLAGS ?= --lint-only --timing --assert
BUILD_FLAGS ?= --binary --timing --assert
RUN_FLAGS ?= +verilator+error+limit+1000

SOURCES := $(shell cat $(FILELIST))
RTL_SOURCES := $(filter-out tb/%,$(SOURCES))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SOURCES)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
